/* common/isaPkg.sv */
package isaPkg;

  typedef logic [3:0] regNum_t;

  // the instruction pointer sits in the top register
  localparam regNum_t REG_IP = 4'd15;

  typedef enum logic [1:0] {
    MODE_IN    = 2'b00,
    MODE_INOUT = 2'b01,
    MODE_OUT   = 2'b10,
    // on the cond operand this means always true
    MODE_NONE  = 2'b11
  } opMode_t;

  typedef struct packed {
    regNum_t regNum;
    opMode_t mode;
  } operandField_t;

  typedef struct packed {
    logic [3:0] spare;
    opMode_t    cndMode;
    opMode_t    dstMode;
    opMode_t    src0Mode;
    opMode_t    src1Mode;
    // pointer bits, cnd/dst/src0/src1 from msb, not interpreted
    logic [3:0] ptrBits;
    regNum_t    cndReg;
    regNum_t    dstReg;
    regNum_t    src0Reg;
    regNum_t    src1Reg;
  } command_t;

  function automatic operandField_t condField(command_t cmd);
    return '{regNum: cmd.cndReg, mode: cmd.cndMode};
  endfunction

  function automatic operandField_t src1Field(command_t cmd);
    return '{regNum: cmd.src1Reg, mode: cmd.src1Mode};
  endfunction

  function automatic operandField_t src0Field(command_t cmd);
    return '{regNum: cmd.src0Reg, mode: cmd.src0Mode};
  endfunction

  function automatic operandField_t dstField(command_t cmd);
    return '{regNum: cmd.dstReg, mode: cmd.dstMode};
  endfunction

  function automatic logic modeFetches(opMode_t mode);
    return mode == MODE_IN || mode == MODE_INOUT;
  endfunction

  function automatic logic modeSaves(opMode_t mode);
    return mode == MODE_INOUT || mode == MODE_OUT;
  endfunction

endpackage

/* common/seqPkg.sv */
package seqPkg;

  import isaPkg::*;

  typedef enum logic [4:0] {
    IDLE,
    DECODE,
    READ_COND,
    FILL_COND,
    READ_SRC1,
    FILL_SRC1,
    READ_SRC0,
    FILL_SRC0,
    READ_DST,
    FILL_DST,
    ALU_RUN,
    WRITE_DST,
    WRITE_COND,
    WRITE_SRC1,
    WRITE_SRC0,
    WRITE_IP,
    FINISH
  } seqState_t;

  typedef enum logic [2:0] {
    ROLE_COND,
    ROLE_SRC1,
    ROLE_SRC0,
    ROLE_DST,
    ROLE_IP
  } operandRole_t;

  typedef enum logic [1:0] {
    OP_READ,
    OP_FILL,
    OP_WRITE
  } opKind_t;

  typedef struct packed {
    opKind_t      kind;
    operandRole_t role;
    regNum_t      regNum;
  } opReq_t;

  // write-back permissions, highest priority first
  typedef struct packed {
    logic dst;
    logic cond;
    logic src1;
    logic src0;
    logic ip;
  } saveGrant_t;

endpackage

/* sequencer/aluTimer.sv */
module aluTimer #(
  parameter int aluCycles = 3
) (
  input  logic clk,
  input  logic rst,
  input  logic aluStart,
  output logic aluDone
);

  logic [3:0] count;
  logic       running;
  logic [3:0] remaining;

  // cycles left, counting the current one
  assign remaining = aluStart ? 4'(aluCycles) : count;
  assign aluDone   = (aluStart || running) && remaining == 4'd1;

  always_ff @(posedge clk) begin
    if (rst) begin
      count   <= '0;
      running <= 1'b0;
    end else if (aluStart || running) begin
      count   <= remaining - 4'd1;
      running <= remaining > 4'd1;
    end
  end

endmodule

/* sequencer/sequencerFsm.sv */
module sequencerFsm import isaPkg::*, seqPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  command_t   command,
  input  logic       busDone,
  input  logic       aluDone,
  input  logic       forwardSrc1,
  input  logic       forwardSrc0,
  input  logic       forwardDst,
  input  saveGrant_t grant,
  output logic       opValid,
  output opReq_t     opReq,
  output logic       aluStart,
  output logic       trackClear,
  output logic       fetched,
  output regNum_t    fetchedReg,
  output command_t   cmdLatched,
  output logic       busy,
  output logic       done
);

  command_t      cmd;
  seqState_t     state;
  seqState_t     nextState;
  logic          firstCycle;
  logic          opState;
  operandField_t cndF;
  operandField_t src1F;
  operandField_t src0F;
  operandField_t dstF;

  assign cndF  = condField(cmd);
  assign src1F = src1Field(cmd);
  assign src0F = src0Field(cmd);
  assign dstF  = dstField(cmd);

  // first operand from pos on (cond, src1, src0, dst) that needs a fetch
  function automatic seqState_t fetchFrom(input logic [1:0] pos);
    seqState_t res;
    res = ALU_RUN;
    if (modeFetches(dstF.mode)) res = forwardDst ? FILL_DST : READ_DST;
    if (pos <= 2'd2 && modeFetches(src0F.mode)) res = forwardSrc0 ? FILL_SRC0 : READ_SRC0;
    if (pos <= 2'd1 && modeFetches(src1F.mode)) res = forwardSrc1 ? FILL_SRC1 : READ_SRC1;
    if (pos == 2'd0 && modeFetches(cndF.mode)) begin
      res = (cndF.regNum == REG_IP) ? FILL_COND : READ_COND;
    end
    return res;
  endfunction

  // first granted write from pos on (dst, cond, src1, src0, ip)
  function automatic seqState_t writeFrom(input logic [2:0] pos);
    seqState_t res;
    res = FINISH;
    if (grant.ip) res = WRITE_IP;
    if (pos <= 3'd3 && grant.src0) res = WRITE_SRC0;
    if (pos <= 3'd2 && grant.src1) res = WRITE_SRC1;
    if (pos <= 3'd1 && grant.cond) res = WRITE_COND;
    if (pos == 3'd0 && grant.dst) res = WRITE_DST;
    return res;
  endfunction

  always_comb begin
    nextState = state;
    case (state)
      IDLE:       if (start) nextState = DECODE;
      DECODE:     nextState = fetchFrom(2'd0);
      READ_COND:  if (busDone) nextState = fetchFrom(2'd1);
      FILL_COND:  nextState = fetchFrom(2'd1);
      READ_SRC1:  if (busDone) nextState = fetchFrom(2'd2);
      FILL_SRC1:  nextState = fetchFrom(2'd2);
      READ_SRC0:  if (busDone) nextState = fetchFrom(2'd3);
      FILL_SRC0:  nextState = fetchFrom(2'd3);
      READ_DST:   if (busDone) nextState = ALU_RUN;
      FILL_DST:   nextState = ALU_RUN;
      ALU_RUN:    if (aluDone) nextState = writeFrom(3'd0);
      WRITE_DST:  if (busDone) nextState = writeFrom(3'd1);
      WRITE_COND: if (busDone) nextState = writeFrom(3'd2);
      WRITE_SRC1: if (busDone) nextState = writeFrom(3'd3);
      WRITE_SRC0: if (busDone) nextState = writeFrom(3'd4);
      WRITE_IP:   if (busDone) nextState = FINISH;
      FINISH:     nextState = IDLE;
      default:    nextState = IDLE;
    endcase
  end

  // request carried by the current state
  always_comb begin
    opState = 1'b1;
    opReq   = '{kind: OP_READ, role: ROLE_COND, regNum: cndF.regNum};
    case (state)
      READ_COND:  opReq = '{kind: OP_READ, role: ROLE_COND, regNum: cndF.regNum};
      FILL_COND:  opReq = '{kind: OP_FILL, role: ROLE_COND, regNum: cndF.regNum};
      READ_SRC1:  opReq = '{kind: OP_READ, role: ROLE_SRC1, regNum: src1F.regNum};
      FILL_SRC1:  opReq = '{kind: OP_FILL, role: ROLE_SRC1, regNum: src1F.regNum};
      READ_SRC0:  opReq = '{kind: OP_READ, role: ROLE_SRC0, regNum: src0F.regNum};
      FILL_SRC0:  opReq = '{kind: OP_FILL, role: ROLE_SRC0, regNum: src0F.regNum};
      READ_DST:   opReq = '{kind: OP_READ, role: ROLE_DST, regNum: dstF.regNum};
      FILL_DST:   opReq = '{kind: OP_FILL, role: ROLE_DST, regNum: dstF.regNum};
      WRITE_DST:  opReq = '{kind: OP_WRITE, role: ROLE_DST, regNum: dstF.regNum};
      WRITE_COND: opReq = '{kind: OP_WRITE, role: ROLE_COND, regNum: cndF.regNum};
      WRITE_SRC1: opReq = '{kind: OP_WRITE, role: ROLE_SRC1, regNum: src1F.regNum};
      WRITE_SRC0: opReq = '{kind: OP_WRITE, role: ROLE_SRC0, regNum: src0F.regNum};
      WRITE_IP:   opReq = '{kind: OP_WRITE, role: ROLE_IP, regNum: REG_IP};
      default:    opState = 1'b0;
    endcase
  end

  // strobes only in the entry cycle of a state
  assign opValid    = firstCycle && opState;
  assign aluStart   = firstCycle && state == ALU_RUN;
  assign trackClear = state == DECODE;
  // a read completes on busDone, a fill in its only cycle
  assign fetched    = opState && opReq.kind != OP_WRITE
                   && (opReq.kind == OP_FILL || busDone);
  assign fetchedReg = opReq.regNum;
  assign busy       = state != IDLE;
  assign done       = state == FINISH;
  assign cmdLatched = cmd;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      firstCycle <= 1'b0;
    end else begin
      state      <= nextState;
      firstCycle <= nextState != state;
    end
  end

  // start is only taken in IDLE
  always_ff @(posedge clk) begin
    if (state == IDLE && start) begin
      cmd <= command;
    end
  end

endmodule

/* logic/operandTracker.sv */
module operandTracker import isaPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  command_t command,
  input  logic     trackClear,
  input  logic     fetched,
  input  regNum_t  fetchedReg,
  output logic     forwardSrc1,
  output logic     forwardSrc0,
  output logic     forwardDst
);

  // one bit per register already fetched in this instruction
  logic [15:0] fetchedMask;
  logic [15:0] maskNow;

  always_ff @(posedge clk) begin
    if (rst) begin
      fetchedMask <= '0;
    end else if (trackClear) begin
      fetchedMask <= '0;
    end else if (fetched) begin
      fetchedMask[fetchedReg] <= 1'b1;
    end
  end

  // the FSM picks the next operand in the same cycle as the fetch strobe,
  // so this cycle's clear and fetch are folded in already
  always_comb begin
    maskNow = trackClear ? '0 : fetchedMask;
    if (fetched) begin
      maskNow[fetchedReg] = 1'b1;
    end
  end

  // ip value is always on hand
  assign forwardSrc1 = (command.src1Reg == REG_IP) || maskNow[command.src1Reg];
  assign forwardSrc0 = (command.src0Reg == REG_IP) || maskNow[command.src0Reg];
  assign forwardDst  = (command.dstReg == REG_IP) || maskNow[command.dstReg];

endmodule

/* logic/saveArbiter.sv */
module saveArbiter import isaPkg::*, seqPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  command_t   command,
  input  logic       aluDone,
  input  logic       condFlag,
  output saveGrant_t grant
);

  operandField_t cndF;
  operandField_t src1F;
  operandField_t src0F;
  operandField_t dstF;
  logic          condTrue;
  logic          condLatch;
  logic          condNow;

  assign cndF  = condField(command);
  assign src1F = src1Field(command);
  assign src0F = src0Field(command);
  assign dstF  = dstField(command);

  // no cond operand means unconditional
  assign condTrue = condFlag || cndF.mode == MODE_NONE;

  always_ff @(posedge clk) begin
    if (rst) begin
      condLatch <= 1'b1;
    end else if (aluDone) begin
      condLatch <= condTrue;
    end
  end

  // FSM picks its first write in the aluDone cycle itself
  assign condNow = aluDone ? condTrue : condLatch;

  // higher priority save already granted on the same register
  function automatic logic taken(logic granted, operandField_t a, operandField_t b);
    return granted && a.regNum == b.regNum;
  endfunction

  always_comb begin
    grant.dst  = dstF.mode != MODE_NONE && condNow;
    grant.cond = modeSaves(cndF.mode) && !taken(grant.dst, dstF, cndF);
    grant.src1 = modeSaves(src1F.mode)
              && !taken(grant.dst, dstF, src1F)
              && !taken(grant.cond, cndF, src1F);
    grant.src0 = modeSaves(src0F.mode)
              && !taken(grant.dst, dstF, src0F)
              && !taken(grant.cond, cndF, src0F)
              && !taken(grant.src1, src1F, src0F);
    // an operand save to ip replaces the normal ip update
    grant.ip   = !((grant.dst && dstF.regNum == REG_IP)
                || (grant.cond && cndF.regNum == REG_IP)
                || (grant.src1 && src1F.regNum == REG_IP)
                || (grant.src0 && src0F.regNum == REG_IP));
  end

endmodule

/* logic/instrSequencer.sv */
module instrSequencer import isaPkg::*, seqPkg::*; #(
  parameter int aluCycles = 3
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     start,
  input  command_t command,
  input  logic     busDone,
  input  logic     condFlag,
  output logic     opValid,
  output opReq_t   opReq,
  output logic     aluStart,
  output logic     busy,
  output logic     done
);

  logic       aluDone;
  logic       trackClear;
  logic       fetched;
  regNum_t    fetchedReg;
  logic       forwardSrc1;
  logic       forwardSrc0;
  logic       forwardDst;
  command_t   cmdLatched;
  saveGrant_t grant;

  sequencerFsm uFsm (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .command     (command),
    .busDone     (busDone),
    .aluDone     (aluDone),
    .forwardSrc1 (forwardSrc1),
    .forwardSrc0 (forwardSrc0),
    .forwardDst  (forwardDst),
    .grant       (grant),
    .opValid     (opValid),
    .opReq       (opReq),
    .aluStart    (aluStart),
    .trackClear  (trackClear),
    .fetched     (fetched),
    .fetchedReg  (fetchedReg),
    .cmdLatched  (cmdLatched),
    .busy        (busy),
    .done        (done)
  );

  aluTimer #(
    .aluCycles (aluCycles)
  ) uTimer (
    .clk      (clk),
    .rst      (rst),
    .aluStart (aluStart),
    .aluDone  (aluDone)
  );

  // tracker and arbiter both look at the command held by the FSM
  operandTracker uTracker (
    .clk         (clk),
    .rst         (rst),
    .command     (cmdLatched),
    .trackClear  (trackClear),
    .fetched     (fetched),
    .fetchedReg  (fetchedReg),
    .forwardSrc1 (forwardSrc1),
    .forwardSrc0 (forwardSrc0),
    .forwardDst  (forwardDst)
  );

  saveArbiter uArbiter (
    .clk      (clk),
    .rst      (rst),
    .command  (cmdLatched),
    .aluDone  (aluDone),
    .condFlag (condFlag),
    .grant    (grant)
  );

endmodule

/* verification/instrSequencer_chk.sv */
module instrSequencer_chk (
  input logic clk,
  input logic rst,
  input logic opValid,
  input logic aluStart,
  input logic busy,
  input logic done
);

  // requests only while an instruction runs
  assert property (@(posedge clk) disable iff (rst) opValid |-> busy)
    else $error("opValid raised while the sequencer is idle");

  // single done pulse, then back to idle
  assert property (@(posedge clk) disable iff (rst) done |=> !done && !busy)
    else $error("done not followed by an idle cycle");

  assert property (@(posedge clk) disable iff (rst) !(aluStart && opValid))
    else $error("aluStart and opValid in the same cycle");

endmodule

bind instrSequencer instrSequencer_chk uChk (.*);

/* verification/instrSequencerTb.sv */
module instrSequencerTb import isaPkg::*, seqPkg::*; ();

  localparam int numRows = 5;
  localparam int maxOps = 5;
  localparam int waitLimit = 300;
  localparam int aluCycles = 3;
  localparam opReq_t noOp = '0;

  // expectations of a row besides its operation list
  typedef struct packed {
    logic       flag;
    logic [2:0] len;
    saveGrant_t grant;
    logic       busyStart;
  } rowInfo_t;

  logic     clk;
  logic     rst;
  logic     start;
  command_t command;
  logic     busDone;
  logic     condFlag;
  logic     opValid;
  opReq_t   opReq;
  logic     aluStart;
  logic     busy;
  logic     done;

  command_t cmds[numRows];
  rowInfo_t infos[numRows];
  opReq_t   exps[numRows][maxOps];
  opReq_t   seen[$];
  int       aluSpan;
  logic     aluCounting;

  instrSequencer #(.aluCycles(aluCycles)) u_dut (.*);

  always #2 clk = ~clk;

  // bus side answers each read or write after 1 to 4 cycles
  always begin
    @(negedge clk);
    if (opValid && opReq.kind != OP_FILL) begin
      repeat ($urandom % 4 + 1) @(posedge clk);
      #1 busDone = 1'b1;
      @(posedge clk);
      #1 busDone = 1'b0;
    end
  end

  // operations in issue order plus the length of the ALU phase
  always @(negedge clk) begin
    if (opValid) begin
      seen.push_back(opReq);
    end
    if (aluStart) begin
      aluCounting = 1'b1;
      aluSpan = 0;
    end
    if (aluCounting) begin
      if (opValid || done) begin
        aluCounting = 1'b0;
      end else begin
        aluSpan++;
      end
    end
  end

  function automatic opReq_t rd(operandRole_t who, int r);
    return '{kind: OP_READ, role: who, regNum: regNum_t'(r)};
  endfunction

  function automatic opReq_t fl(operandRole_t who, int r);
    return '{kind: OP_FILL, role: who, regNum: regNum_t'(r)};
  endfunction

  function automatic opReq_t wr(operandRole_t who, int r);
    return '{kind: OP_WRITE, role: who, regNum: regNum_t'(r)};
  endfunction

  function automatic command_t cmdOf(opMode_t cm, regNum_t cr, opMode_t s1m, regNum_t s1r,
                                     opMode_t s0m, regNum_t s0r, opMode_t dm, regNum_t dr);
    // pointer bits all set and ignored by the design
    return '{spare: 4'h0, cndMode: cm, dstMode: dm, src0Mode: s0m, src1Mode: s1m,
             ptrBits: 4'hf, cndReg: cr, dstReg: dr, src0Reg: s0r, src1Reg: s1r};
  endfunction

  task automatic stopRun();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic checkOp(opReq_t got, opReq_t exp);
    if (got !== exp) begin
      $display("Fail %0t: operation %h, expected %h", $time, got, exp);
      stopRun();
    end
  endtask

  task automatic checkCount(int got, int exp);
    if (got != exp) begin
      $display("Fail %0t: %0d operations, expected %0d", $time, got, exp);
      stopRun();
    end
  endtask

  task automatic checkGrant(saveGrant_t got, saveGrant_t exp);
    if (got !== exp) begin
      $display("Fail %0t: save grant %b, expected %b", $time, got, exp);
      stopRun();
    end
  endtask

  task automatic checkAluSpan(int got, int exp);
    if (got != exp) begin
      $display("Fail %0t: ALU phase of %0d cycles, expected %0d", $time, got, exp);
      stopRun();
    end
  endtask

  task automatic waitDone();
    int cycles;
    cycles = 0;
    while (!done) begin
      @(negedge clk);
      cycles++;
      if (cycles > waitLimit) begin
        $display("timeout, the DUT never raised done within %0d cycles", waitLimit);
        stopRun();
      end
    end
  endtask

  task automatic runRow(int row);
    aluSpan = 0;
    command = cmds[row];
    condFlag = infos[row].flag;
    start = 1'b1;
    @(posedge clk);
    #1 start = 1'b0;
    if (infos[row].busyStart) begin
      // second command lands during the first read and must be dropped
      @(posedge clk);
      #1 command = ~cmds[row];
      start = 1'b1;
      @(posedge clk);
      #1 start = 1'b0;
    end
    waitDone();
    checkCount(seen.size(), int'(infos[row].len));
    for (int i = 0; i < int'(infos[row].len); i++) begin
      checkOp(seen[i], exps[row][i]);
    end
    checkGrant(u_dut.grant, infos[row].grant);
    checkAluSpan(aluSpan, aluCycles);
    seen.delete();
    @(posedge clk);
    #1;
  endtask

  // grant bits are dst, cond, src1, src0, ip
  task automatic loadTable();
    // plain reads with a second start while busy
    cmds[0] = cmdOf(MODE_IN, 4'd1, MODE_IN, 4'd2, MODE_IN, 4'd3, MODE_NONE, 4'd4);
    infos[0] = '{flag: 1'b1, len: 3'd4, grant: 5'b00001, busyStart: 1'b1};
    exps[0] = '{rd(ROLE_COND, 1), rd(ROLE_SRC1, 2), rd(ROLE_SRC0, 3), wr(ROLE_IP, 15), noOp};
    // cond on ip and src0 repeating src1 are forwarded
    cmds[1] = cmdOf(MODE_IN, 4'd15, MODE_IN, 4'd6, MODE_IN, 4'd6, MODE_NONE, 4'd0);
    infos[1] = '{flag: 1'b1, len: 3'd4, grant: 5'b00001, busyStart: 1'b0};
    exps[1] = '{fl(ROLE_COND, 15), rd(ROLE_SRC1, 6), fl(ROLE_SRC0, 6), wr(ROLE_IP, 15), noOp};
    // false condition blocks the dst save
    cmds[2] = cmdOf(MODE_IN, 4'd1, MODE_IN, 4'd2, MODE_NONE, 4'd0, MODE_OUT, 4'd7);
    infos[2] = '{flag: 1'b0, len: 3'd3, grant: 5'b00001, busyStart: 1'b0};
    exps[2] = '{rd(ROLE_COND, 1), rd(ROLE_SRC1, 2), wr(ROLE_IP, 15), noOp, noOp};
    // no cond operand so dst is saved with the flag low
    cmds[3] = cmdOf(MODE_NONE, 4'd0, MODE_IN, 4'd2, MODE_IN, 4'd3, MODE_OUT, 4'd7);
    infos[3] = '{flag: 1'b0, len: 3'd4, grant: 5'b10001, busyStart: 1'b0};
    exps[3] = '{rd(ROLE_SRC1, 2), rd(ROLE_SRC0, 3), wr(ROLE_DST, 7), wr(ROLE_IP, 15), noOp};
    // src1 loses r5 to dst and the src0 save to ip replaces the ip write
    cmds[4] = cmdOf(MODE_NONE, 4'd0, MODE_INOUT, 4'd5, MODE_INOUT, 4'd15, MODE_OUT, 4'd5);
    infos[4] = '{flag: 1'b1, len: 3'd4, grant: 5'b10010, busyStart: 1'b0};
    exps[4] = '{rd(ROLE_SRC1, 5), fl(ROLE_SRC0, 15), wr(ROLE_DST, 5), wr(ROLE_SRC0, 15), noOp};
  endtask

  initial begin
    void'($urandom(15));
    clk = 1'b0;
    rst = 1'b1;
    start = 1'b0;
    command = '0;
    busDone = 1'b0;
    condFlag = 1'b0;
    aluSpan = 0;
    aluCounting = 1'b0;
    loadTable();
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
    for (int r = 0; r < numRows; r++) begin
      runRow(r);
    end
    $display("sim passed");
    $finish;
  end

endmodule

/* vlog.f */
common/isaPkg.sv
common/seqPkg.sv
sequencer/aluTimer.sv
sequencer/sequencerFsm.sv
logic/operandTracker.sv
logic/saveArbiter.sv
logic/instrSequencer.sv
verification/instrSequencer_chk.sv
verification/instrSequencerTb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = instrSequencerTb
FILELIST  = vlog.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
